// ==== verilog.f ====
+incdir+.
tlb_pkg.sv
tlb_op_decode.sv
tlb_entry_array.sv
tlb_lookup.sv
tlb_result.sv
tlb_unit.sv
tb_tlb_unit.sv

// ==== tb_tlb_unit.sv ====
// self-checking testbench for tlb_unit with a fixed two-edge op latency
// expected results come from a model of the 32 entries and travel a two-stage pipeline
`timescale 1ns/10ps
`include "tlb_params.svh"

module tb_tlb_unit;

    localparam int CLK_PERIOD = 100;
    localparam int DRIVE_DLY  = 10;
    localparam int K_NONE = 0, K_SRCH = 1, K_RD = 2, K_DONE = 3, K_ERR = 4;
    // ops per test in run order, with room for the drains between tests
    localparam int OPS_TOTAL  = 8 + 80 + 64 + 64 + 7 * 73 + 70 + 60;

    logic clk, rst_n, op_valid;
    tlb_pkg::tlb_op_t op_code;
    logic [4:0] inv_op;
    tlb_pkg::tlb_index_t op_index, res_index;
    tlb_pkg::asid_t op_asid, w_asid, rd_asid;
    tlb_pkg::vaddr_t op_vaddr;
    tlb_pkg::vpn2_t w_vpn2, rd_vpn2;
    tlb_pkg::ps_t w_ps, rd_ps;
    tlb_pkg::pfn_t w_pfn0, w_pfn1, rd_pfn0, rd_pfn1;
    tlb_pkg::mat_t w_mat0, w_mat1, rd_mat0, rd_mat1, res_mat;
    tlb_pkg::plv_t w_plv0, w_plv1, rd_plv0, rd_plv1, res_plv;
    logic w_e, w_g, w_d0, w_v0, w_d1, w_v1;
    logic done, error, res_hit, res_d, res_v;
    logic rd_e, rd_g, rd_d0, rd_v0, rd_d1, rd_v1;
    tlb_pkg::paddr_t res_paddr;

    // reference model of the entry array
    tlb_pkg::vpn2_t m_vpn2 [`TLB_NUM];
    tlb_pkg::asid_t m_asid [`TLB_NUM];
    tlb_pkg::ps_t   m_ps [`TLB_NUM];
    logic           m_e [`TLB_NUM];
    logic           m_g [`TLB_NUM];
    tlb_pkg::pfn_t  m_pfn [`TLB_NUM][2];
    tlb_pkg::mat_t  m_mat [`TLB_NUM][2];
    tlb_pkg::plv_t  m_plv [`TLB_NUM][2];
    logic           m_d [`TLB_NUM][2];
    logic           m_v [`TLB_NUM][2];

    logic [2:0]  exp0_kind, exp1_kind, exp2_kind;
    logic [43:0] exp0_srch, exp1_srch, exp2_srch;
    logic [88:0] exp0_rd, exp1_rd, exp2_rd;
    logic [43:0] srch_vec;
    logic [88:0] rd_vec;
    string       test_name;
    int          mismatch_count, other_count, rst_cycles, seed_val;

    tlb_unit i_dut (.*);

    assign srch_vec = {res_hit, res_index, res_paddr, res_mat, res_plv, res_d, res_v};
    assign rd_vec   = {rd_vpn2, rd_asid, rd_ps, rd_e, rd_g, rd_pfn0, rd_mat0, rd_plv0,
                       rd_d0, rd_v0, rd_pfn1, rd_mat1, rd_plv1, rd_d1, rd_v1};

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        exp1_kind <= exp0_kind;
        exp1_srch <= exp0_srch;
        exp1_rd   <= exp0_rd;
        exp2_kind <= exp1_kind;     // lines up with done one edge later
        exp2_srch <= exp1_srch;
        exp2_rd   <= exp1_rd;
        if (!rst_n)
            rst_cycles++;
    end

    a_done_seen: assert property (@(posedge clk) disable iff (!rst_n)
        done == (exp2_kind == K_SRCH || exp2_kind == K_RD || exp2_kind == K_DONE))
        else begin
            other_count++;
            $display("%s: done was %0b at %0t but the op stream called for %0b", test_name,
                     $sampled(done), $time, !$sampled(done));
        end

    a_error_seen: assert property (@(posedge clk) disable iff (!rst_n)
        error == (exp2_kind == K_ERR))
        else begin
            other_count++;
            $display("%s: error was %0b at %0t, which the op stream did not call for",
                     test_name, $sampled(error), $time);
        end

    a_search_result: assert property (@(posedge clk) disable iff (!rst_n)
        (exp2_kind == K_SRCH) |-> (srch_vec == exp2_srch))
        else begin
            mismatch_count++;
            $display("MISMATCH %s search: expected %h actual %h", test_name,
                     $sampled(exp2_srch), $sampled(srch_vec));
        end

    a_read_result: assert property (@(posedge clk) disable iff (!rst_n)
        (exp2_kind == K_RD) |-> (rd_vec == exp2_rd))
        else begin
            mismatch_count++;
            $display("MISMATCH %s read: expected %h actual %h", test_name,
                     $sampled(exp2_rd), $sampled(rd_vec));
        end

    // the first edge is skipped since the result flops only clear there
    a_quiet_in_reset: assert property (@(posedge clk)
        (!rst_n && rst_cycles > 0) |-> (!done && !error))
        else begin
            other_count++;
            $display("done or error went high while reset was held at %0t", $time);
        end

    function automatic logic [43:0] expect_search(input logic [31:0] va, input logic [9:0] asid);
        logic [31:0] mask;
        logic [31:0] base;
        int          ps;
        int          pg;
        for (int i = 0; i < `TLB_NUM; i++) begin
            ps = m_ps[i];
            // the pair spans 2 << ps bytes so everything above bit ps is compared
            if (m_e[i] && (m_g[i] || m_asid[i] == asid)
                && (({m_vpn2[i], 13'b0} >> (ps + 1)) == (va >> (ps + 1)))) begin
                pg   = va[ps];
                mask = (32'd1 << ps) - 32'd1;
                base = {m_pfn[i][pg], 12'b0};
                return {1'b1, 5'(i), (base & ~mask) | (va & mask), m_mat[i][pg],
                        m_plv[i][pg], m_d[i][pg], m_v[i][pg]};
            end
        end
        return '0;
    endfunction

    function automatic logic [88:0] expect_read(input int idx);
        if (!m_e[idx])
            return '0;
        return {m_vpn2[idx], m_asid[idx], m_ps[idx], 1'b1, m_g[idx],
                m_pfn[idx][0], m_mat[idx][0], m_plv[idx][0], m_d[idx][0], m_v[idx][0],
                m_pfn[idx][1], m_mat[idx][1], m_plv[idx][1], m_d[idx][1], m_v[idx][1]};
    endfunction

    task automatic apply_invalidate(input int code, input logic [9:0] asid,
                                    input logic [31:0] va);
        logic same_asid;
        logic same_va;
        logic clear;
        for (int i = 0; i < `TLB_NUM; i++) begin
            same_asid = m_asid[i] == asid;
            same_va   = m_vpn2[i] == va[31:13];
            case (code)
                0, 1:    clear = 1'b1;
                2:       clear = m_g[i];
                3:       clear = !m_g[i];
                4:       clear = !m_g[i] && same_asid;
                5:       clear = !m_g[i] && same_asid && same_va;
                default: clear = (m_g[i] || same_asid) && same_va;
            endcase
            if (clear)
                m_e[i] = 1'b0;
        end
    endtask

    task automatic wait_slot();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic drive_op(input tlb_pkg::tlb_op_t code, input int idx,
                            input logic [9:0] asid, input logic [31:0] va, input int inv);
        op_valid = 1'b1;
        op_code  = code;
        op_index = tlb_pkg::tlb_index_t'(idx);
        op_asid  = asid;
        op_vaddr = va;
        inv_op   = 5'(inv);
        case (code)
            tlb_pkg::OP_SRCH: begin
                exp0_kind = K_SRCH;
                exp0_srch = expect_search(va, asid);
            end
            tlb_pkg::OP_RD: begin
                exp0_kind = K_RD;
                exp0_rd   = expect_read(idx);
            end
            tlb_pkg::OP_WR: exp0_kind = K_DONE;
            default: begin
                if (inv <= 6) begin
                    apply_invalidate(inv, asid, va);
                    exp0_kind = K_DONE;
                end else begin
                    exp0_kind = K_ERR;   // an illegal code leaves the model alone
                end
            end
        endcase
    endtask

    task automatic issue(input tlb_pkg::tlb_op_t code, input int idx,
                         input logic [9:0] asid, input logic [31:0] va, input int inv);
        wait_slot();
        drive_op(code, idx, asid, va, inv);
    endtask

    task automatic idle();
        wait_slot();
        op_valid  = 1'b0;
        exp0_kind = K_NONE;
    endtask

    task automatic drain();
        idle();
        while (exp1_kind != K_NONE || exp2_kind != K_NONE)
            idle();
    endtask

    // ps_mode 0 gives 4 KB, 1 gives 2 MB, 2 mixes both; narrow packs vpn2 into four values
    task automatic write_random(input int idx, input int ps_mode, input bit e_rand,
                                input bit narrow);
        wait_slot();
        w_vpn2 = narrow ? {8'h5a, 2'($urandom_range(3)), 9'h0c3} : 19'($urandom);
        w_asid = 10'($urandom_range(3));
        w_ps   = (ps_mode == 0 || (ps_mode == 2 && $urandom_range(1) == 0)) ? `PS_4K : `PS_2M;
        w_e    = e_rand ? $urandom_range(7) != 0 : 1'b1;
        w_g    = $urandom_range(3) == 0;
        w_pfn0 = 20'($urandom);
        w_pfn1 = 20'($urandom);
        {w_mat0, w_plv0, w_d0, w_v0} = 6'($urandom);
        {w_mat1, w_plv1, w_d1, w_v1} = 6'($urandom);
        m_vpn2[idx] = w_vpn2;
        m_asid[idx] = w_asid;
        m_ps[idx]   = w_ps;
        m_e[idx]    = w_e;
        m_g[idx]    = w_g;
        {m_pfn[idx][0], m_mat[idx][0], m_plv[idx][0], m_d[idx][0], m_v[idx][0]} =
            {w_pfn0, w_mat0, w_plv0, w_d0, w_v0};
        {m_pfn[idx][1], m_mat[idx][1], m_plv[idx][1], m_d[idx][1], m_v[idx][1]} =
            {w_pfn1, w_mat1, w_plv1, w_d1, w_v1};
        drive_op(tlb_pkg::OP_WR, idx, '0, '0, 0);
    endtask

    task automatic fill_all(input int ps_mode, input bit e_rand, input bit narrow);
        for (int i = 0; i < `TLB_NUM; i++)
            write_random(i, ps_mode, e_rand, narrow);
    endtask

    task automatic read_all();
        for (int i = 0; i < `TLB_NUM; i++)
            issue(tlb_pkg::OP_RD, i, '0, '0, 0);
    endtask

    initial begin
        int idx;
        logic [9:0] asid;
        rst_n = 1'b0;
        op_valid = 1'b0;
        op_code = tlb_pkg::OP_SRCH;
        {inv_op, op_index, op_asid, op_vaddr} = '0;
        {w_vpn2, w_asid, w_ps, w_e, w_g, w_pfn0, w_mat0, w_plv0, w_d0, w_v0} = '0;
        {w_pfn1, w_mat1, w_plv1, w_d1, w_v1} = '0;
        {exp0_kind, exp0_srch, exp0_rd} = '0;
        {mismatch_count, other_count, rst_cycles} = '0;
        test_name = "reset";
        seed_val = $urandom(32'h3cf8d620);
        for (int i = 0; i < `TLB_NUM; i++) begin
            {m_vpn2[i], m_asid[i], m_ps[i], m_e[i], m_g[i]} = '0;
            for (int p = 0; p < 2; p++)
                {m_pfn[i][p], m_mat[i][p], m_plv[i][p], m_d[i][p], m_v[i][p]} = '0;
        end
        repeat (5) @(posedge clk);
        #DRIVE_DLY rst_n = 1'b1;

        test_name = "after_reset";
        for (int k = 0; k < 4; k++) begin
            issue(tlb_pkg::OP_SRCH, 0, 10'($urandom), $urandom, 0);
            issue(tlb_pkg::OP_RD, $urandom_range(31), '0, '0, 0);
        end
        drain();

        test_name = "write_read";
        fill_all(2, 1'b1, 1'b0);
        read_all();
        for (int k = 0; k < 8; k++) begin
            idx = $urandom_range(31);
            write_random(idx, 2, 1'b0, 1'b0);
            issue(tlb_pkg::OP_RD, idx, '0, '0, 0);  // lands right behind the write
        end
        drain();

        test_name = "search_4k";
        fill_all(0, 1'b0, 1'b0);
        for (int k = 0; k < 32; k++) begin
            idx  = $urandom_range(31);
            asid = (k % 2 == 0) ? m_asid[idx] : m_asid[idx] + 10'd1;
            if (k % 4 == 3)
                issue(tlb_pkg::OP_SRCH, 0, asid, $urandom, 0);
            else
                issue(tlb_pkg::OP_SRCH, 0, asid,
                      {m_vpn2[idx], 1'($urandom), 12'($urandom)}, 0);
        end
        drain();

        test_name = "search_2m";
        fill_all(1, 1'b0, 1'b0);
        for (int k = 0; k < 32; k++) begin
            idx  = $urandom_range(31);
            asid = (k % 2 == 0) ? m_asid[idx] : m_asid[idx] + 10'd1;
            issue(tlb_pkg::OP_SRCH, 0, asid, {m_vpn2[idx][18:9], 22'($urandom)}, 0);
        end
        drain();

        for (int code = 0; code <= 6; code++) begin
            test_name = $sformatf("invalidate_%0d", code);
            fill_all(2, 1'b0, 1'b1);
            idx = $urandom_range(31);
            issue(tlb_pkg::OP_INV, 0, 10'($urandom_range(3)),
                  {m_vpn2[idx], 13'($urandom)}, code);
            read_all();
            for (int k = 0; k < 8; k++) begin
                idx = $urandom_range(31);
                issue(tlb_pkg::OP_SRCH, 0, 10'($urandom_range(3)),
                      {m_vpn2[idx], 13'($urandom)}, 0);
            end
            drain();
        end

        test_name = "illegal_invalidate";
        fill_all(2, 1'b0, 1'b1);
        for (int k = 0; k < 6; k++) begin
            idx = (k == 0) ? 7 : (k == 1) ? 8 : (k == 2) ? 15 : (k == 3) ? 31
                                                            : $urandom_range(31, 7);
            issue(tlb_pkg::OP_INV, 0, 10'($urandom_range(3)), {m_vpn2[0], 13'h0}, idx);
        end
        read_all();
        drain();

        $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        #((OPS_TOTAL * 4 + 50) * CLK_PERIOD);
        other_count++;
        $display("timeout: the tests did not finish within %0d clock cycles",
                 OPS_TOTAL * 4 + 50);
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
        $display("Regression failed");
        $finish;
    end

endmodule

// ==== tlb_unit.sv ====
// management TLB with a fixed two-edge latency from op_valid to done
// one op may start every cycle and a write is seen by the very next op
`timescale 1ns/10ps
`include "tlb_params.svh"

module tlb_unit (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                op_valid,
    input  tlb_pkg::tlb_op_t    op_code,
    input  logic [4:0]          inv_op,
    input  tlb_pkg::tlb_index_t op_index,
    input  tlb_pkg::asid_t      op_asid,
    input  tlb_pkg::vaddr_t     op_vaddr,
    input  tlb_pkg::vpn2_t      w_vpn2,
    input  tlb_pkg::asid_t      w_asid,
    input  tlb_pkg::ps_t        w_ps,
    input  logic                w_e, w_g,
    input  tlb_pkg::pfn_t       w_pfn0, w_pfn1,
    input  tlb_pkg::mat_t       w_mat0, w_mat1,
    input  tlb_pkg::plv_t       w_plv0, w_plv1,
    input  logic                w_d0, w_v0, w_d1, w_v1,
    output logic                done,
    output logic                error,
    output logic                res_hit,
    output tlb_pkg::tlb_index_t res_index,
    output tlb_pkg::paddr_t     res_paddr,
    output tlb_pkg::mat_t       res_mat,
    output tlb_pkg::plv_t       res_plv,
    output logic                res_d, res_v,
    output tlb_pkg::vpn2_t      rd_vpn2,
    output tlb_pkg::asid_t      rd_asid,
    output tlb_pkg::ps_t        rd_ps,
    output logic                rd_e, rd_g,
    output tlb_pkg::pfn_t       rd_pfn0, rd_pfn1,
    output tlb_pkg::mat_t       rd_mat0, rd_mat1,
    output tlb_pkg::plv_t       rd_plv0, rd_plv1,
    output logic                rd_d0, rd_v0, rd_d1, rd_v1
);

    logic                          cmd_srch, cmd_rd, cmd_wr, cmd_inv, bad_op;
    tlb_pkg::inv_mode_t            inv_mode;
    tlb_pkg::tlb_index_t           cmd_index, hit_index;
    tlb_pkg::asid_t                cmd_asid, wr_asid, r_asid;
    tlb_pkg::vaddr_t               cmd_vaddr;
    tlb_pkg::vpn2_t                wr_vpn2, r_vpn2;
    tlb_pkg::ps_t                  wr_ps, r_ps, hit_ps;
    tlb_pkg::pfn_t                 wr_pfn0, wr_pfn1, r_pfn0, r_pfn1, hit_pfn;
    tlb_pkg::mat_t                 wr_mat0, wr_mat1, r_mat0, r_mat1, hit_mat;
    tlb_pkg::plv_t                 wr_plv0, wr_plv1, r_plv0, r_plv1, hit_plv;
    logic                          wr_e, wr_g, wr_d0, wr_v0, wr_d1, wr_v1;
    logic                          r_e, r_g, r_d0, r_v0, r_d1, r_v1;
    logic                          hit, hit_d, hit_v;
    logic [`TLB_NUM*19-1:0]        all_vpn2;
    logic [`TLB_NUM*10-1:0]        all_asid;
    logic [`TLB_NUM*6-1:0]         all_ps;
    logic [`TLB_NUM*20-1:0]        all_pfn0, all_pfn1;
    logic [`TLB_NUM*2-1:0]         all_mat0, all_mat1, all_plv0, all_plv1;
    logic [`TLB_NUM-1:0]           all_g, all_e, all_d0, all_v0, all_d1, all_v1;

    tlb_op_decode i_decode (.*);

    // the array is fed from the decode registers and never from the raw inputs
    tlb_entry_array i_array (
        .*,
        .we        (cmd_wr),
        .inv_en    (cmd_inv),
        .inv_asid  (cmd_asid),
        .inv_vaddr (cmd_vaddr),
        .w_index   (cmd_index),
        .r_index   (cmd_index),
        .w_vpn2    (wr_vpn2),
        .w_asid    (wr_asid),
        .w_ps      (wr_ps),
        .w_e       (wr_e),
        .w_g       (wr_g),
        .w_pfn0    (wr_pfn0),
        .w_mat0    (wr_mat0),
        .w_plv0    (wr_plv0),
        .w_d0      (wr_d0),
        .w_v0      (wr_v0),
        .w_pfn1    (wr_pfn1),
        .w_mat1    (wr_mat1),
        .w_plv1    (wr_plv1),
        .w_d1      (wr_d1),
        .w_v1      (wr_v1)
    );

    tlb_lookup i_lookup (
        .*,
        .vaddr (cmd_vaddr),
        .asid  (cmd_asid)
    );

    tlb_result i_result (.*);

endmodule

// ==== tlb_result.sv ====
// result fields are valid only in the cycle that done is high
// a search miss returns zero index and zero address fields
`timescale 1ns/10ps
`include "tlb_params.svh"

module tlb_result (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cmd_srch, cmd_rd, cmd_wr, cmd_inv,
    input  logic                bad_op,
    input  tlb_pkg::vaddr_t     cmd_vaddr,
    input  logic                hit,
    input  tlb_pkg::tlb_index_t hit_index,
    input  tlb_pkg::pfn_t       hit_pfn,
    input  tlb_pkg::ps_t        hit_ps,
    input  tlb_pkg::mat_t       hit_mat,
    input  tlb_pkg::plv_t       hit_plv,
    input  logic                hit_d, hit_v,
    input  tlb_pkg::vpn2_t      r_vpn2,
    input  tlb_pkg::asid_t      r_asid,
    input  tlb_pkg::ps_t        r_ps,
    input  logic                r_e, r_g,
    input  tlb_pkg::pfn_t       r_pfn0, r_pfn1,
    input  tlb_pkg::mat_t       r_mat0, r_mat1,
    input  tlb_pkg::plv_t       r_plv0, r_plv1,
    input  logic                r_d0, r_v0, r_d1, r_v1,
    output logic                done,
    output logic                error,
    output logic                res_hit,
    output tlb_pkg::tlb_index_t res_index,
    output tlb_pkg::paddr_t     res_paddr,
    output tlb_pkg::mat_t       res_mat,
    output tlb_pkg::plv_t       res_plv,
    output logic                res_d, res_v,
    output tlb_pkg::vpn2_t      rd_vpn2,
    output tlb_pkg::asid_t      rd_asid,
    output tlb_pkg::ps_t        rd_ps,
    output logic                rd_e, rd_g,
    output tlb_pkg::pfn_t       rd_pfn0, rd_pfn1,
    output tlb_pkg::mat_t       rd_mat0, rd_mat1,
    output tlb_pkg::plv_t       rd_plv0, rd_plv1,
    output logic                rd_d0, rd_v0, rd_d1, rd_v1
);

    tlb_pkg::paddr_t paddr;

    // the page offset comes straight from the virtual address
    assign paddr = (hit_ps == `PS_2M) ? {hit_pfn[19:9], cmd_vaddr[20:0]}
                                      : {hit_pfn, cmd_vaddr[11:0]};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            done  <= 1'b0;
            error <= 1'b0;
        end else begin
            done  <= cmd_srch | cmd_rd | cmd_wr | cmd_inv;
            error <= bad_op;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_srch) begin
            res_hit   <= hit;
            res_index <= hit ? hit_index : '0;
            res_paddr <= hit ? paddr : '0;
            res_mat   <= hit ? hit_mat : '0;
            res_plv   <= hit ? hit_plv : '0;
            res_d     <= hit & hit_d;
            res_v     <= hit & hit_v;
        end
        if (cmd_rd) begin
            rd_vpn2 <= r_vpn2;
            rd_asid <= r_asid;
            rd_ps   <= r_ps;
            rd_e    <= r_e;
            rd_g    <= r_g;
            rd_pfn0 <= r_pfn0;
            rd_mat0 <= r_mat0;
            rd_plv0 <= r_plv0;
            rd_d0   <= r_d0;
            rd_v0   <= r_v0;
            rd_pfn1 <= r_pfn1;
            rd_mat1 <= r_mat1;
            rd_plv1 <= r_plv1;
            rd_d1   <= r_d1;
            rd_v1   <= r_v1;
        end
    end

    a_done_xor_error: assert property (@(posedge clk) disable iff (!rst_n) !(done && error));

endmodule

// ==== tlb_lookup.sv ====
// fully associative search, purely combinational
// any ps other than 12 is matched as a 2 MB page
`timescale 1ns/10ps
`include "tlb_params.svh"

module tlb_lookup (
    input  logic [`TLB_NUM*19-1:0] all_vpn2,
    input  logic [`TLB_NUM*10-1:0] all_asid,
    input  logic [`TLB_NUM*6-1:0]  all_ps,
    input  logic [`TLB_NUM-1:0]    all_g, all_e,
    input  logic [`TLB_NUM*20-1:0] all_pfn0, all_pfn1,
    input  logic [`TLB_NUM*2-1:0]  all_mat0, all_mat1,
    input  logic [`TLB_NUM*2-1:0]  all_plv0, all_plv1,
    input  logic [`TLB_NUM-1:0]    all_d0, all_v0, all_d1, all_v1,
    input  tlb_pkg::vaddr_t        vaddr,
    input  tlb_pkg::asid_t         asid,
    output logic                   hit,
    output tlb_pkg::tlb_index_t    hit_index,
    output tlb_pkg::pfn_t          hit_pfn,
    output tlb_pkg::ps_t           hit_ps,
    output tlb_pkg::mat_t          hit_mat,
    output tlb_pkg::plv_t          hit_plv,
    output logic                   hit_d,
    output logic                   hit_v
);

    logic [`TLB_NUM-1:0] match;
    logic                odd;

    always_comb begin
        for (int i = 0; i < `TLB_NUM; i++) begin
            // a 2 MB pair only compares vpn2 bits 18:9, which are vaddr 31:22
            if (all_ps[i*6 +: 6] == `PS_4K)
                match[i] = all_vpn2[i*19 +: 19] == vaddr[31:13];
            else
                match[i] = all_vpn2[i*19+9 +: 10] == vaddr[31:22];
            match[i] = match[i] && all_e[i]
                       && (all_g[i] || all_asid[i*10 +: 10] == asid);
        end
    end

    // scan downward so the lowest matching index is left standing
    always_comb begin
        hit_index = '0;
        for (int i = `TLB_NUM - 1; i >= 0; i--) begin
            if (match[i])
                hit_index = tlb_pkg::tlb_index_t'(i);
        end
    end

    assign hit    = |match;
    assign hit_ps = all_ps[hit_index*6 +: 6];
    assign odd    = (hit_ps == `PS_4K) ? vaddr[12] : vaddr[21]; // picks page 1 of the pair

    assign hit_pfn = odd ? all_pfn1[hit_index*20 +: 20] : all_pfn0[hit_index*20 +: 20];
    assign hit_mat = odd ? all_mat1[hit_index*2 +: 2] : all_mat0[hit_index*2 +: 2];
    assign hit_plv = odd ? all_plv1[hit_index*2 +: 2] : all_plv0[hit_index*2 +: 2];
    assign hit_d   = odd ? all_d1[hit_index] : all_d0[hit_index];
    assign hit_v   = odd ? all_v1[hit_index] : all_v0[hit_index];

endmodule

// ==== tlb_entry_array.sv ====
// 32 paired-page entries with one write or one invalidate per cycle
// reset clears only the enable bits and the other fields start unknown
`timescale 1ns/10ps
`include "tlb_params.svh"

module tlb_entry_array (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          we,
    input  logic                          inv_en,
    input  tlb_pkg::inv_mode_t            inv_mode,
    input  tlb_pkg::asid_t                inv_asid,
    input  tlb_pkg::vaddr_t               inv_vaddr,
    input  tlb_pkg::tlb_index_t           w_index,
    input  tlb_pkg::vpn2_t                w_vpn2,
    input  tlb_pkg::asid_t                w_asid,
    input  tlb_pkg::ps_t                  w_ps,
    input  logic                          w_e,
    input  logic                          w_g,
    input  tlb_pkg::pfn_t                 w_pfn0, w_pfn1,
    input  tlb_pkg::mat_t                 w_mat0, w_mat1,
    input  tlb_pkg::plv_t                 w_plv0, w_plv1,
    input  logic                          w_d0, w_v0, w_d1, w_v1,
    input  tlb_pkg::tlb_index_t           r_index,
    output tlb_pkg::vpn2_t                r_vpn2,
    output tlb_pkg::asid_t                r_asid,
    output tlb_pkg::ps_t                  r_ps,
    output logic                          r_e,
    output logic                          r_g,
    output tlb_pkg::pfn_t                 r_pfn0, r_pfn1,
    output tlb_pkg::mat_t                 r_mat0, r_mat1,
    output tlb_pkg::plv_t                 r_plv0, r_plv1,
    output logic                          r_d0, r_v0, r_d1, r_v1,
    output logic [`TLB_NUM*19-1:0]        all_vpn2,
    output logic [`TLB_NUM*10-1:0]        all_asid,
    output logic [`TLB_NUM*6-1:0]         all_ps,
    output logic [`TLB_NUM-1:0]           all_g, all_e,
    output logic [`TLB_NUM*20-1:0]        all_pfn0, all_pfn1,
    output logic [`TLB_NUM*2-1:0]         all_mat0, all_mat1,
    output logic [`TLB_NUM*2-1:0]         all_plv0, all_plv1,
    output logic [`TLB_NUM-1:0]           all_d0, all_v0, all_d1, all_v1
);

    // packed per entry so the flat buses are plain copies, entry i at the low end
    tlb_pkg::vpn2_t [`TLB_NUM-1:0] vpn2_q;
    tlb_pkg::asid_t [`TLB_NUM-1:0] asid_q;
    tlb_pkg::ps_t   [`TLB_NUM-1:0] ps_q;
    tlb_pkg::pfn_t  [`TLB_NUM-1:0] pfn0_q, pfn1_q;
    tlb_pkg::mat_t  [`TLB_NUM-1:0] mat0_q, mat1_q;
    tlb_pkg::plv_t  [`TLB_NUM-1:0] plv0_q, plv1_q;
    logic [`TLB_NUM-1:0]           e_q, g_q, d0_q, v0_q, d1_q, v1_q;
    logic [`TLB_NUM-1:0]           inv_hit;
    logic                          r_en;

    always_comb begin
        for (int i = 0; i < `TLB_NUM; i++) begin
            case (inv_mode)
                tlb_pkg::INV_ALL:     inv_hit[i] = 1'b1;
                tlb_pkg::INV_G1:      inv_hit[i] = g_q[i];
                tlb_pkg::INV_G0:      inv_hit[i] = !g_q[i];
                tlb_pkg::INV_G0_ASID: inv_hit[i] = !g_q[i] && asid_q[i] == inv_asid;
                tlb_pkg::INV_G0_ASID_VA:
                    inv_hit[i] = !g_q[i] && asid_q[i] == inv_asid
                                 && vpn2_q[i] == inv_vaddr[31:13];
                tlb_pkg::INV_G1_OR_ASID_VA:
                    inv_hit[i] = (g_q[i] || asid_q[i] == inv_asid)
                                 && vpn2_q[i] == inv_vaddr[31:13];
                default:              inv_hit[i] = 1'b0;
            endcase
        end
    end

    // invalidate wins over a write in the same cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            e_q <= '0;
        end else if (inv_en) begin
            e_q <= e_q & ~inv_hit;
        end else if (we) begin
            e_q[w_index] <= w_e;
        end
    end

    always_ff @(posedge clk) begin
        if (we && !inv_en) begin
            vpn2_q[w_index] <= w_vpn2;
            asid_q[w_index] <= w_asid;
            ps_q[w_index]   <= w_ps;
            g_q[w_index]    <= w_g;
            pfn0_q[w_index] <= w_pfn0;
            mat0_q[w_index] <= w_mat0;
            plv0_q[w_index] <= w_plv0;
            d0_q[w_index]   <= w_d0;
            v0_q[w_index]   <= w_v0;
            pfn1_q[w_index] <= w_pfn1;
            mat1_q[w_index] <= w_mat1;
            plv1_q[w_index] <= w_plv1;
            d1_q[w_index]   <= w_d1;
            v1_q[w_index]   <= w_v1;
        end
    end

    assign r_en   = e_q[r_index];
    assign r_e    = r_en;               // e itself is never masked
    assign r_vpn2 = r_en ? vpn2_q[r_index] : '0;
    assign r_asid = r_en ? asid_q[r_index] : '0;
    assign r_ps   = r_en ? ps_q[r_index] : '0;
    assign r_g    = r_en & g_q[r_index];
    assign r_pfn0 = r_en ? pfn0_q[r_index] : '0;
    assign r_mat0 = r_en ? mat0_q[r_index] : '0;
    assign r_plv0 = r_en ? plv0_q[r_index] : '0;
    assign r_d0   = r_en & d0_q[r_index];
    assign r_v0   = r_en & v0_q[r_index];
    assign r_pfn1 = r_en ? pfn1_q[r_index] : '0;
    assign r_mat1 = r_en ? mat1_q[r_index] : '0;
    assign r_plv1 = r_en ? plv1_q[r_index] : '0;
    assign r_d1   = r_en & d1_q[r_index];
    assign r_v1   = r_en & v1_q[r_index];

    assign all_vpn2 = vpn2_q;
    assign all_asid = asid_q;
    assign all_ps   = ps_q;
    assign all_g    = g_q;
    assign all_e    = e_q;
    assign all_pfn0 = pfn0_q;
    assign all_mat0 = mat0_q;
    assign all_plv0 = plv0_q;
    assign all_d0   = d0_q;
    assign all_v0   = v0_q;
    assign all_pfn1 = pfn1_q;
    assign all_mat1 = mat1_q;
    assign all_plv1 = plv1_q;
    assign all_d1   = d1_q;
    assign all_v1   = v1_q;

    // decode never issues both, so the priority above stays a safety net
    a_no_wr_inv: assert property (@(posedge clk) disable iff (!rst_n) !(we && inv_en));

endmodule

// ==== tlb_op_decode.sv ====
// takes one management strobe per cycle and has no back-pressure
// invalidate codes above 6 do nothing except raise bad_op
`timescale 1ns/10ps

module tlb_op_decode (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                op_valid,
    input  tlb_pkg::tlb_op_t    op_code,
    input  logic [4:0]          inv_op,
    input  tlb_pkg::tlb_index_t op_index,
    input  tlb_pkg::asid_t      op_asid,
    input  tlb_pkg::vaddr_t     op_vaddr,
    input  tlb_pkg::vpn2_t      w_vpn2,
    input  tlb_pkg::asid_t      w_asid,
    input  tlb_pkg::ps_t        w_ps,
    input  logic                w_e,
    input  logic                w_g,
    input  tlb_pkg::pfn_t       w_pfn0, w_pfn1,
    input  tlb_pkg::mat_t       w_mat0, w_mat1,
    input  tlb_pkg::plv_t       w_plv0, w_plv1,
    input  logic                w_d0, w_v0, w_d1, w_v1,
    output logic                cmd_srch, cmd_rd, cmd_wr, cmd_inv,
    output logic                bad_op,
    output tlb_pkg::inv_mode_t  inv_mode,
    output tlb_pkg::tlb_index_t cmd_index,
    output tlb_pkg::asid_t      cmd_asid,
    output tlb_pkg::vaddr_t     cmd_vaddr,
    output tlb_pkg::vpn2_t      wr_vpn2,
    output tlb_pkg::asid_t      wr_asid,
    output tlb_pkg::ps_t        wr_ps,
    output logic                wr_e,
    output logic                wr_g,
    output tlb_pkg::pfn_t       wr_pfn0, wr_pfn1,
    output tlb_pkg::mat_t       wr_mat0, wr_mat1,
    output tlb_pkg::plv_t       wr_plv0, wr_plv1,
    output logic                wr_d0, wr_v0, wr_d1, wr_v1
);

    tlb_pkg::inv_mode_t inv_mode_d;
    logic               inv_legal;
    logic               is_inv;

    assign is_inv = op_valid && op_code == tlb_pkg::OP_INV;

    always_comb begin
        inv_legal = 1'b1;
        case (inv_op)
            5'd0, 5'd1: inv_mode_d = tlb_pkg::INV_ALL;
            5'd2:       inv_mode_d = tlb_pkg::INV_G1;
            5'd3:       inv_mode_d = tlb_pkg::INV_G0;
            5'd4:       inv_mode_d = tlb_pkg::INV_G0_ASID;
            5'd5:       inv_mode_d = tlb_pkg::INV_G0_ASID_VA;
            5'd6:       inv_mode_d = tlb_pkg::INV_G1_OR_ASID_VA;
            default: begin
                inv_mode_d = tlb_pkg::INV_ALL;
                inv_legal  = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cmd_srch <= 1'b0;
            cmd_rd   <= 1'b0;
            cmd_wr   <= 1'b0;
            cmd_inv  <= 1'b0;
            bad_op   <= 1'b0;
        end else begin
            cmd_srch <= op_valid && op_code == tlb_pkg::OP_SRCH;
            cmd_rd   <= op_valid && op_code == tlb_pkg::OP_RD;
            cmd_wr   <= op_valid && op_code == tlb_pkg::OP_WR;
            cmd_inv  <= is_inv && inv_legal;
            bad_op   <= is_inv && !inv_legal;
        end
    end

    // operands move only with a strobe so they stay paired with the command
    always_ff @(posedge clk) begin
        if (op_valid) begin
            inv_mode  <= inv_mode_d;
            cmd_index <= op_index;
            cmd_asid  <= op_asid;
            cmd_vaddr <= op_vaddr;
            wr_vpn2   <= w_vpn2;
            wr_asid   <= w_asid;
            wr_ps     <= w_ps;
            wr_e      <= w_e;
            wr_g      <= w_g;
            wr_pfn0   <= w_pfn0;
            wr_mat0   <= w_mat0;
            wr_plv0   <= w_plv0;
            wr_d0     <= w_d0;
            wr_v0     <= w_v0;
            wr_pfn1   <= w_pfn1;
            wr_mat1   <= w_mat1;
            wr_plv1   <= w_plv1;
            wr_d1     <= w_d1;
            wr_v1     <= w_v1;
        end
    end

    a_cmd_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({cmd_srch, cmd_rd, cmd_wr, cmd_inv, bad_op}));

endmodule

// ==== tlb_pkg.sv ====
// entry field types and the op and invalidate encodings
// entries are paired pages, so vpn2 drops vaddr bit 12
`include "tlb_params.svh"

package tlb_pkg;

    typedef logic [31:0] vaddr_t;
    typedef logic [31:0] paddr_t;
    typedef logic [18:0] vpn2_t;    // vaddr[31:13]
    typedef logic [9:0]  asid_t;
    typedef logic [5:0]  ps_t;
    typedef logic [19:0] pfn_t;
    typedef logic [1:0]  mat_t;
    typedef logic [1:0]  plv_t;
    typedef logic [`TLB_INDEX_W-1:0] tlb_index_t;

    typedef enum logic [1:0] {
        OP_SRCH,
        OP_RD,
        OP_WR,
        OP_INV
    } tlb_op_t;

    // raw invalidate codes 2 to 6 follow this order from INV_G1 on
    typedef enum logic [2:0] {
        INV_ALL,
        INV_G1,
        INV_G0,
        INV_G0_ASID,
        INV_G0_ASID_VA,
        INV_G1_OR_ASID_VA
    } inv_mode_t;

endpackage

// ==== tlb_params.svh ====
// sizes of the TLB and the two legal page-size codes
// TLB_INDEX_W must stay equal to clog2 of TLB_NUM
`ifndef TLB_PARAMS_SVH
`define TLB_PARAMS_SVH

`define TLB_NUM     32
`define TLB_INDEX_W 5

// page-size codes as written in the ps field of an entry
`define PS_4K       6'd12
`define PS_2M       6'd21

`endif
